/* sim.f */
design/draw_pkg.sv
design/scene_pkg.sv
design/cmd_if.sv
design/scene_sequencer.sv
design/cmd_buffer.sv
design/shape_rasterizer.sv
design/scene_renderer.sv
tests/plot_checker.sv
tests/tb_scene_renderer.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_scene_renderer
FILELIST = sim.f

LOG      = sim.log
SIM      = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_scene_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scene_renderer;
    import draw_pkg::*;
    import scene_pkg::*;

    localparam logic [31:0] SEED = 32'h1b1420b8;
    localparam int RESET_CYCLES   = 16;
    localparam int TOTAL_FRAMES   = 15;  // Sum over the test list
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * FRAME_CMDS * 100 * 4 + RESET_CYCLES;

    logic        clock_50;
    logic        rst_n;
    logic        start;
    logic [2:0]  jump_level;
    coord_t      scroll;
    logic        plot_ready;
    wire         plot;
    wire coord_t  x;
    wire coord_t  y;
    wire colour_t colour;
    wire         frame_done;
    int          checker_errors;
    int          checked_pixels;
    logic [31:0] rng_state;
    logic [31:0] ready_state;
    logic        ready_random;  // Back-pressure on
    int          cycle_count;
    int          tests_run;
    int          tests_failed;

    scene_renderer i_scene_renderer (
        .clock_50   (clock_50),
        .rst_n      (rst_n),
        .start      (start),
        .jump_level (jump_level),
        .scroll     (scroll),
        .plot_ready (plot_ready),
        .plot       (plot),
        .x          (x),
        .y          (y),
        .colour     (colour),
        .frame_done (frame_done)
    );

    plot_checker i_plot_checker (
        .clock_50    (clock_50),
        .rst_n       (rst_n),
        .start       (start),
        .jump_level  (jump_level),
        .scroll      (scroll),
        .plot_ready  (plot_ready),
        .plot        (plot),
        .x           (x),
        .y           (y),
        .colour      (colour),
        .frame_done  (frame_done),
        .error_count (checker_errors),
        .pixel_count (checked_pixels)
    );

    always #50 clock_50 = ~clock_50;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r         = rng_state;
    endtask

    // About half the cycles stall when enabled
    always @(negedge clock_50) begin
        if (ready_random) begin
            ready_state = xorshift32(ready_state);
            plot_ready  = ready_state[4];
        end else begin
            plot_ready = 1'b1;
        end
    end

    always @(posedge clock_50) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic drive_start(input logic [2:0] j, input coord_t s, input int hold);
        logic [31:0] r;
        @(negedge clock_50);
        jump_level = j;
        scroll     = s;
        start      = 1'b1;
        repeat (hold) @(negedge clock_50);
        start = 1'b0;
        next_rand(r);
        jump_level = r[2:0];  // DUT must keep its captured values
        scroll     = coord_t'(r[26:16]);
    endtask

    task automatic wait_frame_done();
        @(posedge clock_50);
        while (frame_done !== 1'b1)
            @(posedge clock_50);
    endtask

    task automatic run_test(input string name, input int frames, input bit rand_jump,
                            input bit rand_scroll, input bit rand_ready, input int hold);
        int          errors_before;
        int          f;
        logic [31:0] r;
        logic [2:0]  j;
        coord_t      s;
        errors_before = checker_errors;
        ready_random  = rand_ready;
        tests_run++;
        if (frames == 0)
            repeat (20) @(posedge clock_50);
        for (f = 0; f < frames; f++) begin
            j = 3'd0;
            s = '0;
            if (rand_jump) begin
                next_rand(r);
                j = (f == 0) ? 3'd7 : r[2:0];  // 7 exercises the clamp
            end
            if (rand_scroll) begin
                next_rand(r);
                s = coord_t'(r % 32'd301);
            end
            drive_start(j, s, hold);
            wait_frame_done();  // Next start follows right away
        end
        ready_random = 1'b0;
        repeat (4) @(posedge clock_50);
        @(negedge clock_50);
        if (checker_errors == errors_before) begin
            $display("test %0d %s: passed, %0d frames", tests_run, name, frames);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     checker_errors - errors_before);
        end
    endtask

    initial begin
        clock_50     = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        jump_level   = 3'd0;
        scroll       = '0;
        plot_ready   = 1'b1;
        ready_random = 1'b0;
        rng_state    = SEED;
        ready_state  = SEED ^ 32'h9e3779b9;  // Own stream for plot_ready
        cycle_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clock_50);
        @(negedge clock_50);
        rst_n = 1'b1;

        run_test("idle after reset", 0, 1'b0, 1'b0, 1'b0, 1);
        run_test("baseline frame", 1, 1'b0, 1'b0, 1'b0, 1);
        run_test("random jump level", 4, 1'b1, 1'b0, 1'b0, 1);
        run_test("random scroll", 4, 1'b1, 1'b1, 1'b0, 1);
        run_test("plot back-pressure", 3, 1'b1, 1'b1, 1'b1, 1);
        run_test("back-to-back starts", 3, 1'b1, 1'b1, 1'b0, 3);

        $display("%0d of %0d tests passed, %0d pixels checked, %0d errors",
                 tests_run - tests_failed, tests_run, checked_pixels, checker_errors);
        if (tests_failed == 0 && checker_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/plot_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Compares every accepted plot against a pixel list built from the scene tables
module plot_checker (
    input  wire                    clock_50,
    input  wire                    rst_n,
    input  wire                    start,
    input  wire [2:0]              jump_level,
    input  wire draw_pkg::coord_t  scroll,
    input  wire                    plot_ready,
    input  wire                    plot,
    input  wire draw_pkg::coord_t  x,
    input  wire draw_pkg::coord_t  y,
    input  wire draw_pkg::colour_t colour,
    input  wire                    frame_done,
    output int                     error_count,
    output int                     pixel_count
);
    import draw_pkg::*;
    import scene_pkg::*;

    typedef struct packed {
        colour_t colour;
        coord_t  x;
        coord_t  y;
    } pixel_t;

    pixel_t exp_q [$];        // Pixels still to come, in plot order
    int     frame_len_q [$];  // Plotted pixels per open frame
    int     frame_pix;
    int     errors = 0;
    int     pixels = 0;
    logic   held;
    pixel_t held_pix;
    pixel_t got;
    pixel_t want;

    assign error_count = errors;
    assign pixel_count = pixels;

    function automatic int add_shape(input shape_kind_t kind, input colour_t c,
                                     input coord_t cx, input coord_t cy);
        coord_t px;
        coord_t py;
        int     r;
        int     col;
        int     n;
        n = 0;
        for (r = 0; r < SHAPE_ROWS; r++) begin
            py = cy + coord_t'(r) - coord_t'(SHAPE_ROWS - 1);  // Top row first
            for (col = int'(SPAN_START[kind][r]); col <= int'(SPAN_END[kind][r]); col++) begin
                px = cx + coord_t'(col);
                // Wrapped negatives land far off screen
                if (px < coord_t'(DISPLAY_W) && py < coord_t'(DISPLAY_H)) begin
                    exp_q.push_back({c, px, py});
                    n++;
                end
            end
        end
        return n;
    endfunction

    function automatic int add_frame(input logic [2:0] jump, input coord_t scr);
        logic [2:0]  lvl;
        shape_kind_t kind;
        int          i;
        int          n;
        lvl = (jump > 3'd6) ? 3'd6 : jump;  // Highest grid level is 6
        n   = add_shape(SHAPE_SQUARE, SQUARE_COLOUR, PLAYER_X, Y_LEVEL[lvl]);
        for (i = 0; i < NUM_OBSTACLES; i++) begin
            kind = OBSTACLE_KIND[i];
            n += add_shape(kind, (kind == SHAPE_SPIKE) ? SPIKE_COLOUR : BLOCK_COLOUR,
                           X_LEVEL[OBSTACLE_X_IDX[i]] - scr, Y_LEVEL[OBSTACLE_Y_IDX[i]]);
        end
        return n;
    endfunction

    task automatic report_mismatch(input pixel_t exp, input pixel_t act);
        $display("[FAIL] %0t: pixel %0d expected (%0d,%0d) colour %0d, got (%0d,%0d) colour %0d",
                 $time, frame_pix, exp.x, exp.y, exp.colour, act.x, act.y, act.colour);
    endtask

    always @(posedge clock_50) begin
        if (!rst_n) begin
            exp_q.delete();
            frame_len_q.delete();
            frame_pix = 0;
            held      = 1'b0;
        end else begin
            got = {colour, x, y};
            if (held && (!plot || got !== held_pix)) begin
                $display("[FAIL] %0t: stalled pixel (%0d,%0d) colour %0d moved or dropped",
                         $time, held_pix.x, held_pix.y, held_pix.colour);
                errors++;
            end
            held     = plot && !plot_ready;
            held_pix = got;

            if (plot && plot_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: pixel (%0d,%0d) was plotted while no frame was open",
                             $time, got.x, got.y);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (got !== want) begin
                        report_mismatch(want, got);
                        errors++;
                    end
                    frame_pix++;
                    pixels++;
                end
            end

            if (frame_done) begin
                if (frame_len_q.size() == 0) begin
                    $display("%0t: frame_done pulsed with no frame in progress", $time);
                    errors++;
                end else begin
                    if (frame_pix != frame_len_q[0]) begin
                        $display("[FAIL] %0t: frame_done after %0d pixels, expected %0d",
                                 $time, frame_pix, frame_len_q[0]);
                        errors++;
                    end
                    void'(frame_len_q.pop_front());
                    frame_pix = 0;
                end
            end

            // Sequencer drops a start while its frame is open
            if (start && frame_len_q.size() == 0)
                frame_len_q.push_back(add_frame(jump_level, scroll));
        end
    end

endmodule

`default_nettype wire

/* design/scene_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

module scene_renderer (
    input  wire                    clock_50,
    input  wire                    rst_n,
    input  wire                    start,       // Begin a frame
    input  wire [2:0]              jump_level,  // Player height, 7 clamps to 6
    input  wire draw_pkg::coord_t  scroll,      // Obstacle shift to the left
    input  wire                    plot_ready,
    output wire                    plot,
    output wire draw_pkg::coord_t  x,
    output wire draw_pkg::coord_t  y,
    output wire draw_pkg::colour_t colour,
    output wire                    frame_done
);
    import draw_pkg::*;

    cmd_if #(.T(draw_cmd_t)) seq_link ();
    cmd_if #(.T(draw_cmd_t)) rast_link ();

    scene_sequencer i_scene_sequencer (
        .clock_50   (clock_50),
        .rst_n      (rst_n),
        .start      (start),
        .jump_level (jump_level),
        .scroll     (scroll),
        .link       (seq_link)
    );

    // Rasterizer holds two commands
    cmd_buffer #(
        .T           (draw_cmd_t),
        .DEPTH       (CMD_DEPTH),
        .OUT_CREDITS (2)
    ) i_cmd_buffer (
        .clock_50 (clock_50),
        .rst_n    (rst_n),
        .in_link  (seq_link),
        .out_link (rast_link)
    );

    shape_rasterizer i_shape_rasterizer (
        .clock_50   (clock_50),
        .rst_n      (rst_n),
        .plot_ready (plot_ready),
        .link       (rast_link),
        .plot       (plot),
        .x          (x),
        .y          (y),
        .colour     (colour),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

/* design/shape_rasterizer.sv */
`timescale 1ns/1ps
`default_nettype none

module shape_rasterizer (
    input  wire                    clock_50,
    input  wire                    rst_n,
    input  wire                    plot_ready,
    cmd_if.receiver                link,
    output logic                   plot,
    output draw_pkg::coord_t       x,
    output draw_pkg::coord_t       y,
    output draw_pkg::colour_t      colour,
    output logic                   frame_done
);
    import draw_pkg::*;
    import scene_pkg::*;

    localparam int STAGE_DEPTH = 2;  // Matches the buffer's downstream credits
    localparam int ROW_W       = $clog2(SHAPE_ROWS);
    localparam int COL_W       = $clog2(SHAPE_COLS);

    draw_cmd_t        stage [STAGE_DEPTH];
    logic             stage_last [STAGE_DEPTH];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic [ROW_W-1:0] row;      // 0 is the top row
    logic [COL_W-1:0] col_off;  // Offset from the row's span start
    draw_cmd_t        head;
    span_t            span_start;
    span_t            span_end;
    span_t            cur_col;
    logic             active;
    logic             on_screen;
    logic             advance;
    logic             row_end;
    logic             shape_end;
    logic             shape_done;

    assign head       = stage[rd_ptr];
    assign active     = count != 2'd0;
    assign span_start = SPAN_START[head.kind][row];
    assign span_end   = SPAN_END[head.kind][row];
    assign cur_col    = span_start + span_t'(col_off);

    // Corner is the bottom-left pixel, so the top row sits nine above it
    assign x      = head.corner_x + coord_t'(cur_col);
    assign y      = head.corner_y - coord_t'(SHAPE_ROWS - 1) + coord_t'(row);
    assign colour = head.colour;

    // Negative coordinates wrap to large values and fail here too
    assign on_screen = (x < coord_t'(DISPLAY_W)) && (y < coord_t'(DISPLAY_H));
    assign plot      = active && on_screen;
    assign advance   = active && (plot_ready || !on_screen);  // Clipped cells never stall

    assign row_end    = cur_col == span_end;
    assign shape_end  = row_end && (row == ROW_W'(SHAPE_ROWS - 1));
    assign shape_done = advance && shape_end;

    assign link.credit = shape_done;

    always_ff @(posedge clock_50) begin
        if (link.valid) begin
            stage[wr_ptr]      <= link.data;
            stage_last[wr_ptr] <= link.last;
        end
    end

    always_ff @(posedge clock_50 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= 2'd0;
            row        <= '0;
            col_off    <= '0;
            frame_done <= 1'b0;
        end else begin
            if (link.valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (shape_done)
                rd_ptr <= rd_ptr + 1'b1;  // Next shape takes over
            count      <= count + {1'b0, link.valid} - {1'b0, shape_done};
            frame_done <= shape_done && stage_last[rd_ptr];

            if (advance) begin
                if (row_end) begin
                    col_off <= '0;
                    row     <= shape_end ? '0 : row + 1'b1;
                end else begin
                    col_off <= col_off + 1'b1;
                end
            end
        end
    end

    // Held pixel must not move under back-pressure
    a_hold_stall: assert property (@(posedge clock_50) disable iff (!rst_n)
        plot && !plot_ready |=> plot && $stable(x) && $stable(y) && $stable(colour));

endmodule

`default_nettype wire

/* design/cmd_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_buffer #(
    parameter type T           = logic,
    parameter int  DEPTH       = draw_pkg::CMD_DEPTH,
    parameter int  OUT_CREDITS = 2
) (
    input  wire       clock_50,
    input  wire       rst_n,
    cmd_if.receiver   in_link,
    cmd_if.sender     out_link
);
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    T                  mem [DEPTH];
    logic              last_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;  // Free slots downstream
    logic              send;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign send = (count != '0) && (credits != '0);

    assign out_link.valid = send;
    assign out_link.data  = mem[rd_ptr];
    assign out_link.last  = last_mem[rd_ptr];
    assign in_link.credit = send;  // Slot frees as the head leaves

    always_ff @(posedge clock_50) begin
        if (in_link.valid) begin
            mem[wr_ptr]      <= in_link.data;
            last_mem[wr_ptr] <= in_link.last;
        end
    end

    always_ff @(posedge clock_50 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRED_W'(OUT_CREDITS);
        end else begin
            if (in_link.valid)
                wr_ptr <= ptr_next(wr_ptr);
            if (send)
                rd_ptr <= ptr_next(rd_ptr);
            count   <= count + CNT_W'(in_link.valid) - CNT_W'(send);
            credits <= credits - CRED_W'(send) + CRED_W'(out_link.credit);
        end
    end

    // Upstream credits must keep the FIFO from overflowing
    a_no_push_full: assert property (@(posedge clock_50) disable iff (!rst_n)
        in_link.valid |-> count != CNT_W'(DEPTH));

    // Downstream never returns more than it was granted
    a_credit_bound: assert property (@(posedge clock_50) disable iff (!rst_n)
        credits <= CRED_W'(OUT_CREDITS));

endmodule

`default_nettype wire

/* design/scene_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module scene_sequencer (
    input  wire                   clock_50,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire [2:0]             jump_level,
    input  wire draw_pkg::coord_t scroll,
    cmd_if.sender                 link
);
    import draw_pkg::*;
    import scene_pkg::*;

    localparam int CRED_W = $clog2(CMD_DEPTH + 1);
    localparam int IDX_W  = $clog2(FRAME_CMDS);

    logic [CRED_W-1:0] credits;
    logic [CRED_W-1:0] credits_nxt;
    logic [IDX_W-1:0]  cmd_idx;   // Command on the link
    logic [IDX_W-1:0]  obs;
    logic              busy;
    logic              valid_q;
    logic              last_cmd;
    logic [2:0]        jump_q;
    coord_t            scroll_q;
    draw_cmd_t         cmd;

    assign credits_nxt = credits - CRED_W'(valid_q) + CRED_W'(link.credit);
    assign last_cmd    = cmd_idx == IDX_W'(FRAME_CMDS - 1);
    assign obs         = cmd_idx - 1'b1;  // Obstacle table index

    always_comb begin
        if (cmd_idx == '0) begin
            // Player square
            cmd.kind     = SHAPE_SQUARE;
            cmd.colour   = SQUARE_COLOUR;
            cmd.corner_x = PLAYER_X;
            cmd.corner_y = Y_LEVEL[jump_q];
        end else begin
            cmd.kind     = OBSTACLE_KIND[obs];
            cmd.colour   = (OBSTACLE_KIND[obs] == SHAPE_SPIKE) ? SPIKE_COLOUR : BLOCK_COLOUR;
            cmd.corner_x = X_LEVEL[OBSTACLE_X_IDX[obs]] - scroll_q;  // May wrap past zero
            cmd.corner_y = Y_LEVEL[OBSTACLE_Y_IDX[obs]];
        end
    end

    assign link.valid = valid_q;
    assign link.data  = cmd;
    assign link.last  = last_cmd;

    // Scene inputs held for the whole frame
    always_ff @(posedge clock_50) begin
        if (start && !busy) begin
            jump_q   <= (jump_level > 3'd6) ? 3'd6 : jump_level;
            scroll_q <= scroll;
        end
    end

    always_ff @(posedge clock_50 or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRED_W'(CMD_DEPTH);
            cmd_idx <= '0;
            busy    <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            credits <= credits_nxt;
            if (!busy) begin
                if (start) begin
                    busy    <= 1'b1;
                    cmd_idx <= '0;
                    valid_q <= credits_nxt != '0;
                end
            end else if (valid_q && last_cmd) begin
                busy    <= 1'b0;  // Frame fully issued
                valid_q <= 1'b0;
            end else begin
                if (valid_q)
                    cmd_idx <= cmd_idx + 1'b1;
                valid_q <= credits_nxt != '0;  // Stall until a credit comes back
            end
        end
    end

    // Receiver never hands back more credits than it was given
    a_credit_bound: assert property (@(posedge clock_50) disable iff (!rst_n)
        credits <= CRED_W'(CMD_DEPTH));

endmodule

`default_nettype wire

/* design/cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Credit-controlled command link. The sender spends one credit per valid,
// the receiver pulses credit once per freed slot
interface cmd_if #(
    parameter type T = logic
);
    logic valid;   // One command this cycle, accepted unconditionally
    logic last;    // Final command of a frame
    T     data;
    logic credit;  // Slot freed at the receiver

    modport sender (
        output valid,
        output last,
        output data,
        input  credit
    );

    modport receiver (
        input  valid,
        input  last,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

/* design/scene_pkg.sv */
`default_nettype none

package scene_pkg;

    // Column offset inside a shape
    typedef logic [3:0] span_t;

    // Bottom edges, ground level first
    localparam draw_pkg::coord_t Y_LEVEL [0:6] = '{
        11'd89, 11'd79, 11'd69, 11'd59, 11'd49, 11'd39, 11'd29
    };

    // Left edges, ten pixels apart
    localparam draw_pkg::coord_t X_LEVEL [0:20] = '{
        11'd89,  11'd99,  11'd109, 11'd119, 11'd129, 11'd139, 11'd149,
        11'd159, 11'd169, 11'd179, 11'd189, 11'd199, 11'd209, 11'd219,
        11'd229, 11'd239, 11'd249, 11'd259, 11'd269, 11'd279, 11'd289
    };

    localparam draw_pkg::coord_t PLAYER_X = 11'd59;  // Player never moves sideways

    localparam int NUM_OBSTACLES = 10;

    // Five blocks then five spikes
    localparam draw_pkg::shape_kind_t OBSTACLE_KIND [0:NUM_OBSTACLES-1] = '{
        draw_pkg::SHAPE_SQUARE, draw_pkg::SHAPE_SQUARE, draw_pkg::SHAPE_SQUARE,
        draw_pkg::SHAPE_SQUARE, draw_pkg::SHAPE_SQUARE,
        draw_pkg::SHAPE_SPIKE,  draw_pkg::SHAPE_SPIKE,  draw_pkg::SHAPE_SPIKE,
        draw_pkg::SHAPE_SPIKE,  draw_pkg::SHAPE_SPIKE
    };
    localparam logic [4:0] OBSTACLE_X_IDX [0:NUM_OBSTACLES-1] = '{
        5'd0, 5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9
    };
    localparam logic [2:0] OBSTACLE_Y_IDX [0:NUM_OBSTACLES-1] = '{
        3'd0, 3'd3, 3'd5, 3'd3, 3'd0, 3'd0, 3'd3, 3'd5, 3'd3, 3'd0
    };

    localparam draw_pkg::colour_t SQUARE_COLOUR = draw_pkg::RED;
    localparam draw_pkg::colour_t BLOCK_COLOUR  = draw_pkg::YELLOW;
    localparam draw_pkg::colour_t SPIKE_COLOUR  = draw_pkg::WHITE;

    // Filled columns per row, top row first, indexed by kind
    localparam span_t SPAN_START [0:1][0:draw_pkg::SHAPE_ROWS-1] = '{
        '{4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd0},
        '{4'd4, 4'd4, 4'd3, 4'd3, 4'd2, 4'd2, 4'd1, 4'd1, 4'd0, 4'd0}
    };
    localparam span_t SPAN_END [0:1][0:draw_pkg::SHAPE_ROWS-1] = '{
        '{4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9, 4'd9},
        '{4'd5, 4'd5, 4'd6, 4'd6, 4'd7, 4'd7, 4'd8, 4'd8, 4'd9, 4'd9}
    };

    localparam int FRAME_CMDS = NUM_OBSTACLES + 1;  // Player first

endpackage

`default_nettype wire

/* design/draw_pkg.sv */
`default_nettype none

package draw_pkg;

    // Screen size in pixels
    localparam int DISPLAY_W = 160;
    localparam int DISPLAY_H = 120;

    localparam int COORD_W = 11;

    // Wide enough for obstacles parked well right of the screen
    typedef logic [COORD_W-1:0] coord_t;

    // One bit per DAC channel, red in the MSB
    typedef enum logic [2:0] {
        BLACK       = 3'b000,
        DARK_BLUE   = 3'b001,
        LIGHT_GREEN = 3'b010,
        LIGHT_BLUE  = 3'b011,
        RED         = 3'b100,
        PINK        = 3'b101,
        YELLOW      = 3'b110,
        WHITE       = 3'b111
    } colour_t;

    // Selects the row-span table
    typedef enum logic {
        SHAPE_SQUARE = 1'b0,  // Player and blocks
        SHAPE_SPIKE  = 1'b1
    } shape_kind_t;

    // One shape, anchored at its bottom-left pixel
    typedef struct packed {
        shape_kind_t kind;
        colour_t     colour;
        coord_t      corner_x;
        coord_t      corner_y;
    } draw_cmd_t;

    localparam int SHAPE_ROWS = 10;
    localparam int SHAPE_COLS = 10;

    localparam int CMD_DEPTH = 4;  // Buffer entries, also the sequencer's credits

endpackage

`default_nettype wire
